// File: hw/aluExec.sv
module aluExec (
	input  mipsPkg::decoded_t dec,
	output mipsPkg::word_t    aluRes
);
	import mipsPkg::*;

	word_t immExt;
	word_t opA;
	word_t opB;

	always_comb begin
		case (dec.ctrl.extOp)
			ExtZero:  immExt = {16'b0, dec.imm};
			ExtUpper: immExt = {dec.imm, 16'b0};
			default:  immExt = {{16{dec.imm[15]}}, dec.imm};
		endcase
	end

	// Fixed shifts put shamt on A
	assign opA = (dec.ctrl.aSel == ASelShamt) ? {{(DataWidth - 5){1'b0}}, dec.shamt}
	                                          : dec.rsVal;
	assign opB = (dec.ctrl.bSel == BSelImm) ? immExt : dec.rtVal;

	////////////////////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (dec.ctrl.aluOp)
			AluAdd:  aluRes = opA + opB;
			AluSub:  aluRes = opA - opB;
			AluAnd:  aluRes = opA & opB;
			AluOr:   aluRes = opA | opB;
			AluXor:  aluRes = opA ^ opB;
			AluNor:  aluRes = ~(opA | opB);
			AluSlt:  aluRes = word_t'($signed(opA) < $signed(opB));
			AluSltu: aluRes = word_t'(opA < opB);
			// Shift amount is the low 5 bits of A, value is B
			AluSll:  aluRes = opB << opA[4:0];
			AluSrl:  aluRes = opB >> opA[4:0];
			AluSra:  aluRes = word_t'($signed(opB) >>> opA[4:0]);
			// Immediate already moved to the upper half
			AluLui:  aluRes = opB;
			default: aluRes = '0;
		endcase
	end

endmodule

// File: hw/branchUnit.sv
module branchUnit (
	input  mipsPkg::decoded_t dec,
	output logic              redirect,
	output mipsPkg::word_t    target,
	output mipsPkg::word_t    linkPc
);
	import mipsPkg::*;

	word_t pcPlus4;
	word_t brOffset;
	logic  taken;

	assign pcPlus4 = dec.pc + 32'd4;
	assign linkPc = dec.pc + 32'd8;
	assign brOffset = {{14{dec.imm[15]}}, dec.imm, 2'b00};

	// Zero compares look at rs only, as signed
	always_comb begin
		case (dec.ctrl.cmpOp)
			CmpEq:   taken = (dec.rsVal == dec.rtVal);
			CmpNe:   taken = (dec.rsVal != dec.rtVal);
			CmpGtz:  taken = ($signed(dec.rsVal) > 0);
			CmpLez:  taken = ($signed(dec.rsVal) <= 0);
			CmpGez:  taken = ($signed(dec.rsVal) >= 0);
			CmpLtz:  taken = ($signed(dec.rsVal) < 0);
			default: taken = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Next PC
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (dec.ctrl.nextPcOp)
			NpcBranch: begin
				redirect = taken;
				target = pcPlus4 + brOffset;
			end
			NpcJump: begin
				redirect = 1'b1;
				target = {pcPlus4[31:28], dec.jumpIndex, 2'b00};
			end
			NpcJumpReg: begin
				redirect = 1'b1;
				target = dec.rsVal;
			end
			default: begin
				redirect = 1'b0;
				target = pcPlus4;
			end
		endcase
	end

endmodule

// File: hw/execCore.sv
module execCore (
	input  logic             clk,
	input  logic             arstN,
	input  logic             instrValid,
	input  mipsPkg::word_t   instr,
	input  mipsPkg::word_t   pc,
	input  mipsPkg::word_t   rsVal,
	input  mipsPkg::word_t   rtVal,
	output logic             resValid,
	output logic             wbEn,
	output mipsPkg::regIdx_t wbReg,
	output mipsPkg::word_t   wbData,
	output logic             redirect,
	output mipsPkg::word_t   target
);
	import mipsPkg::*;

	decoded_t dec;
	word_t    aluRes;
	word_t    hi;
	word_t    lo;
	word_t    linkPc;
	word_t    brTarget;
	logic     brRedirect;

	instrDecode uDecode (
		.clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr),
		.pc(pc), .rsVal(rsVal), .rtVal(rtVal), .dec(dec)
	);

	aluExec uAlu (.dec(dec), .aluRes(aluRes));

	hiLoUnit uHiLo (.clk(clk), .arstN(arstN), .dec(dec), .hi(hi), .lo(lo));

	branchUnit uBranch (
		.dec(dec), .redirect(brRedirect), .target(brTarget), .linkPc(linkPc)
	);

	resultStage uResult (
		.clk(clk), .arstN(arstN), .dec(dec), .aluRes(aluRes), .hi(hi), .lo(lo),
		.linkPc(linkPc), .brTarget(brTarget), .brRedirect(brRedirect),
		.resValid(resValid), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
		.redirect(redirect), .target(target)
	);

endmodule

// File: hw/hiLoUnit.sv
module hiLoUnit (
	input  logic              clk,
	input  logic              arstN,
	input  mipsPkg::decoded_t dec,
	output mipsPkg::word_t    hi,
	output mipsPkg::word_t    lo
);
	import mipsPkg::*;

	logic signed [2*DataWidth-1:0] sProd;
	logic        [2*DataWidth-1:0] uProd;

	assign sProd = $signed(dec.rsVal) * $signed(dec.rtVal);
	assign uProd = dec.rsVal * dec.rtVal;

	// Written at the edge that also registers the result
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			hi <= '0;
			lo <= '0;
		end else if (dec.valid) begin
			case (dec.ctrl.mulOp)
				MulMult:  {hi, lo} <= sProd;
				MulMultu: {hi, lo} <= uProd;
				MulMthi:  hi <= dec.rsVal;
				MulMtlo:  lo <= dec.rsVal;
				default: begin
					hi <= hi;
					lo <= lo;
				end
			endcase
		end
	end

endmodule

// File: hw/instrDecode.sv
module instrDecode (
	input  logic              clk,
	input  logic              arstN,
	input  logic              instrValid,
	input  mipsPkg::word_t    instr,
	input  mipsPkg::word_t    pc,
	input  mipsPkg::word_t    rsVal,
	input  mipsPkg::word_t    rtVal,
	output mipsPkg::decoded_t dec
);
	import mipsPkg::*;

	instr_t   ir;
	ctrl_t    ctrl;
	decoded_t decNext;

	// Register write from the ALU
	function automatic ctrl_t aluCtrl(aluOp_t op, aSel_t aSel, bSel_t bSel, extOp_t ext,
			dstSel_t dst);
		ctrl_t c;
		c = CtrlNop;
		c.aluOp = op;
		c.aSel = aSel;
		c.bSel = bSel;
		c.extOp = ext;
		c.dstSel = dst;
		c.wbEn = 1'b1;
		return c;
	endfunction

	function automatic ctrl_t brCtrl(cmpOp_t cmp);
		ctrl_t c;
		c = CtrlNop;
		c.cmpOp = cmp;
		c.nextPcOp = NpcBranch;
		return c;
	endfunction

	assign ir = instr;

	////////////////////////////////////////////////////////////////////////////
	// Opcode and function decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrl = CtrlNop;
		case (ir.r.op)
			OpSpecial: begin
				case (ir.r.funct)
					FnAdd, FnAddu: ctrl = aluCtrl(AluAdd, ASelRs, BSelRt, ExtSign, DstRd);
					FnSub, FnSubu: ctrl = aluCtrl(AluSub, ASelRs, BSelRt, ExtSign, DstRd);
					FnAnd:  ctrl = aluCtrl(AluAnd, ASelRs, BSelRt, ExtSign, DstRd);
					FnOr:   ctrl = aluCtrl(AluOr, ASelRs, BSelRt, ExtSign, DstRd);
					FnXor:  ctrl = aluCtrl(AluXor, ASelRs, BSelRt, ExtSign, DstRd);
					FnNor:  ctrl = aluCtrl(AluNor, ASelRs, BSelRt, ExtSign, DstRd);
					FnSlt:  ctrl = aluCtrl(AluSlt, ASelRs, BSelRt, ExtSign, DstRd);
					FnSltu: ctrl = aluCtrl(AluSltu, ASelRs, BSelRt, ExtSign, DstRd);
					// Fixed shifts take shamt, variable ones take rs
					FnSll:  ctrl = aluCtrl(AluSll, ASelShamt, BSelRt, ExtSign, DstRd);
					FnSrl:  ctrl = aluCtrl(AluSrl, ASelShamt, BSelRt, ExtSign, DstRd);
					FnSra:  ctrl = aluCtrl(AluSra, ASelShamt, BSelRt, ExtSign, DstRd);
					FnSllv: ctrl = aluCtrl(AluSll, ASelRs, BSelRt, ExtSign, DstRd);
					FnSrlv: ctrl = aluCtrl(AluSrl, ASelRs, BSelRt, ExtSign, DstRd);
					FnSrav: ctrl = aluCtrl(AluSra, ASelRs, BSelRt, ExtSign, DstRd);
					FnJr:   ctrl.nextPcOp = NpcJumpReg;
					FnJalr: begin
						ctrl.nextPcOp = NpcJumpReg;
						ctrl.wbSel = WbLink;
						ctrl.wbEn = 1'b1;
					end
					FnMfhi: begin
						ctrl.wbSel = WbHi;
						ctrl.wbEn = 1'b1;
					end
					FnMflo: begin
						ctrl.wbSel = WbLo;
						ctrl.wbEn = 1'b1;
					end
					FnMult:  ctrl.mulOp = MulMult;
					FnMultu: ctrl.mulOp = MulMultu;
					FnMthi:  ctrl.mulOp = MulMthi;
					FnMtlo:  ctrl.mulOp = MulMtlo;
					default: ctrl = CtrlNop;
				endcase
			end
			OpRegImm: begin
				case (ir.i.rt)
					RtBgez:  ctrl = brCtrl(CmpGez);
					RtBltz:  ctrl = brCtrl(CmpLtz);
					default: ctrl = CtrlNop;
				endcase
			end
			OpBeq:  ctrl = brCtrl(CmpEq);
			OpBne:  ctrl = brCtrl(CmpNe);
			OpBgtz: ctrl = brCtrl(CmpGtz);
			OpBlez: ctrl = brCtrl(CmpLez);
			OpJ:    ctrl.nextPcOp = NpcJump;
			OpJal: begin
				ctrl.nextPcOp = NpcJump;
				ctrl.wbSel = WbLink;
				ctrl.dstSel = DstLink;
				ctrl.wbEn = 1'b1;
			end
			// No overflow trap, addi acts as addiu
			OpAddi, OpAddiu: ctrl = aluCtrl(AluAdd, ASelRs, BSelImm, ExtSign, DstRt);
			OpSlti:  ctrl = aluCtrl(AluSlt, ASelRs, BSelImm, ExtSign, DstRt);
			OpSltiu: ctrl = aluCtrl(AluSltu, ASelRs, BSelImm, ExtSign, DstRt);
			OpAndi:  ctrl = aluCtrl(AluAnd, ASelRs, BSelImm, ExtZero, DstRt);
			OpOri:   ctrl = aluCtrl(AluOr, ASelRs, BSelImm, ExtZero, DstRt);
			OpXori:  ctrl = aluCtrl(AluXor, ASelRs, BSelImm, ExtZero, DstRt);
			OpLui:   ctrl = aluCtrl(AluLui, ASelRs, BSelImm, ExtUpper, DstRt);
			default: ctrl = CtrlNop;
		endcase
	end

	always_comb begin
		decNext.valid = instrValid;
		decNext.ctrl = ctrl;
		decNext.rsVal = rsVal;
		decNext.rtVal = rtVal;
		decNext.imm = ir.i.imm;
		decNext.shamt = ir.r.shamt;
		decNext.rd = ir.r.rd;
		decNext.rt = ir.r.rt;
		decNext.jumpIndex = ir.j.index;
		decNext.pc = pc;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			dec <= '0;
		end else begin
			dec <= decNext;
		end
	end

endmodule

// File: hw/mipsPkg.sv
package mipsPkg;

	localparam int DataWidth = 32;

	typedef logic [DataWidth-1:0] word_t;
	typedef logic [4:0] regIdx_t;

	localparam regIdx_t LinkReg = 5'd31;

	////////////////////////////////////////////////////////////////////////////
	// Instruction formats
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [5:0] op;
		regIdx_t    rs;
		regIdx_t    rt;
		regIdx_t    rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFmt_t;

	typedef struct packed {
		logic [5:0]  op;
		regIdx_t     rs;
		regIdx_t     rt;
		logic [15:0] imm;
	} iFmt_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] index;
	} jFmt_t;

	typedef union packed {
		rFmt_t r;
		iFmt_t i;
		jFmt_t j;
	} instr_t;

	// Primary opcodes
	localparam logic [5:0] OpSpecial = 6'b000000;
	localparam logic [5:0] OpRegImm  = 6'b000001;
	localparam logic [5:0] OpJ       = 6'b000010;
	localparam logic [5:0] OpJal     = 6'b000011;
	localparam logic [5:0] OpBeq     = 6'b000100;
	localparam logic [5:0] OpBne     = 6'b000101;
	localparam logic [5:0] OpBlez    = 6'b000110;
	localparam logic [5:0] OpBgtz    = 6'b000111;
	localparam logic [5:0] OpAddi    = 6'b001000;
	localparam logic [5:0] OpAddiu   = 6'b001001;
	localparam logic [5:0] OpSlti    = 6'b001010;
	localparam logic [5:0] OpSltiu   = 6'b001011;
	localparam logic [5:0] OpAndi    = 6'b001100;
	localparam logic [5:0] OpOri     = 6'b001101;
	localparam logic [5:0] OpXori    = 6'b001110;
	localparam logic [5:0] OpLui     = 6'b001111;

	// SPECIAL function field
	localparam logic [5:0] FnSll   = 6'b000000;
	localparam logic [5:0] FnSrl   = 6'b000010;
	localparam logic [5:0] FnSra   = 6'b000011;
	localparam logic [5:0] FnSllv  = 6'b000100;
	localparam logic [5:0] FnSrlv  = 6'b000110;
	localparam logic [5:0] FnSrav  = 6'b000111;
	localparam logic [5:0] FnJr    = 6'b001000;
	localparam logic [5:0] FnJalr  = 6'b001001;
	localparam logic [5:0] FnMfhi  = 6'b010000;
	localparam logic [5:0] FnMthi  = 6'b010001;
	localparam logic [5:0] FnMflo  = 6'b010010;
	localparam logic [5:0] FnMtlo  = 6'b010011;
	localparam logic [5:0] FnMult  = 6'b011000;
	localparam logic [5:0] FnMultu = 6'b011001;
	localparam logic [5:0] FnAdd   = 6'b100000;
	localparam logic [5:0] FnAddu  = 6'b100001;
	localparam logic [5:0] FnSub   = 6'b100010;
	localparam logic [5:0] FnSubu  = 6'b100011;
	localparam logic [5:0] FnAnd   = 6'b100100;
	localparam logic [5:0] FnOr    = 6'b100101;
	localparam logic [5:0] FnXor   = 6'b100110;
	localparam logic [5:0] FnNor   = 6'b100111;
	localparam logic [5:0] FnSlt   = 6'b101010;
	localparam logic [5:0] FnSltu  = 6'b101011;

	// REGIMM selects on rt
	localparam logic [4:0] RtBltz = 5'b00000;
	localparam logic [4:0] RtBgez = 5'b00001;

	////////////////////////////////////////////////////////////////////////////
	// Decoded controls
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		AluAdd, AluSub, AluAnd, AluOr, AluXor, AluNor,
		AluSlt, AluSltu, AluSll, AluSrl, AluSra, AluLui
	} aluOp_t;

	typedef enum logic {ASelRs, ASelShamt} aSel_t;
	typedef enum logic {BSelRt, BSelImm} bSel_t;
	typedef enum logic [1:0] {ExtSign, ExtZero, ExtUpper} extOp_t;
	typedef enum logic [2:0] {CmpEq, CmpNe, CmpGtz, CmpLez, CmpGez, CmpLtz} cmpOp_t;
	typedef enum logic [1:0] {NpcSeq, NpcBranch, NpcJump, NpcJumpReg} nextPcOp_t;
	typedef enum logic [2:0] {MulNone, MulMult, MulMultu, MulMthi, MulMtlo} mulOp_t;
	typedef enum logic [1:0] {WbAlu, WbHi, WbLo, WbLink} wbSel_t;
	typedef enum logic [1:0] {DstRd, DstRt, DstLink} dstSel_t;

	typedef struct packed {
		aluOp_t    aluOp;
		aSel_t     aSel;
		bSel_t     bSel;
		extOp_t    extOp;
		cmpOp_t    cmpOp;
		nextPcOp_t nextPcOp;
		mulOp_t    mulOp;
		wbSel_t    wbSel;
		dstSel_t   dstSel;
		logic      wbEn;
	} ctrl_t;

	// No-op: no write-back, sequential PC, HI/LO untouched
	localparam ctrl_t CtrlNop = '{
		aluOp: AluAdd, aSel: ASelRs, bSel: BSelRt, extOp: ExtSign,
		cmpOp: CmpEq, nextPcOp: NpcSeq, mulOp: MulNone,
		wbSel: WbAlu, dstSel: DstRd, wbEn: 1'b0
	};

	typedef struct packed {
		logic        valid;
		ctrl_t       ctrl;
		word_t       rsVal;
		word_t       rtVal;
		logic [15:0] imm;
		logic [4:0]  shamt;
		regIdx_t     rd;
		regIdx_t     rt;
		logic [25:0] jumpIndex;
		word_t       pc;
	} decoded_t;

	typedef struct packed {
		logic    valid;
		logic    wbEn;
		wbSel_t  wbSel;
		regIdx_t dst;
		word_t   aluRes;
		word_t   hi;
		word_t   lo;
		word_t   linkPc;
		logic    redirect;
		word_t   target;
	} execResult_t;

endpackage

// File: hw/resultStage.sv
module resultStage (
	input  logic              clk,
	input  logic              arstN,
	input  mipsPkg::decoded_t dec,
	input  mipsPkg::word_t    aluRes,
	input  mipsPkg::word_t    hi,
	input  mipsPkg::word_t    lo,
	input  mipsPkg::word_t    linkPc,
	input  mipsPkg::word_t    brTarget,
	input  logic              brRedirect,
	output logic              resValid,
	output logic              wbEn,
	output mipsPkg::regIdx_t  wbReg,
	output mipsPkg::word_t    wbData,
	output logic              redirect,
	output mipsPkg::word_t    target
);
	import mipsPkg::*;

	execResult_t resNext;
	execResult_t res;

	always_comb begin
		resNext.valid = dec.valid;
		case (dec.ctrl.dstSel)
			DstRt:   resNext.dst = dec.rt;
			DstLink: resNext.dst = LinkReg;
			default: resNext.dst = dec.rd;
		endcase
		// Register 0 is never written
		resNext.wbEn = dec.valid & dec.ctrl.wbEn & (resNext.dst != '0);
		resNext.wbSel = dec.ctrl.wbSel;
		resNext.aluRes = aluRes;
		resNext.hi = hi;
		resNext.lo = lo;
		resNext.linkPc = linkPc;
		resNext.redirect = dec.valid & brRedirect;
		resNext.target = brTarget;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			res <= '0;
		end else begin
			res <= resNext;
		end
	end

	always_comb begin
		case (res.wbSel)
			WbHi:    wbData = res.hi;
			WbLo:    wbData = res.lo;
			WbLink:  wbData = res.linkPc;
			default: wbData = res.aluRes;
		endcase
	end

	assign resValid = res.valid;
	assign wbEn = res.wbEn;
	assign wbReg = res.dst;
	assign redirect = res.redirect;
	assign target = res.target;

endmodule

// File: src.f
+incdir+tests
hw/mipsPkg.sv
hw/instrDecode.sv
hw/aluExec.sv
hw/hiLoUnit.sv
hw/branchUnit.sv
hw/resultStage.sv
hw/execCore.sv
tests/execCoreTb.sv

// File: tests/mipsModel.svh
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH

// Expected result beat for one issued instruction
typedef struct packed {
	logic        wbEn;
	logic [4:0]  wbReg;
	logic [31:0] wbData;
	logic        redirect;
	logic        checkTarget;
	logic [31:0] target;
	logic [31:0] issueCycle;
} expect_t;

// Model HI/LO starts at zero like the DUT after reset
logic [31:0] modelHi = '0;
logic [31:0] modelLo = '0;

function automatic expect_t predictInstr(input logic [31:0] ins, input logic [31:0] pcVal,
		input logic [31:0] a, input logic [31:0] b);
	expect_t     e;
	logic [5:0]  op;
	logic [5:0]  fn;
	logic [4:0]  rtF;
	logic [4:0]  sh;
	logic [31:0] sImm;
	logic [31:0] zImm;
	logic [31:0] pc4;
	logic [63:0] prod;
	logic        wr;
	logic        isBr;
	logic        take;
	logic [4:0]  dst;
	logic [31:0] data;
	op = ins[31:26];
	fn = ins[5:0];
	rtF = ins[20:16];
	sh = ins[10:6];
	sImm = {{16{ins[15]}}, ins[15:0]};
	zImm = {16'h0000, ins[15:0]};
	pc4 = pcVal + 32'd4;
	e = '0;
	wr = 1'b0;
	isBr = 1'b0;
	take = 1'b0;
	dst = ins[15:11];
	data = '0;
	case (op)
		6'h00: begin
			case (fn)
				6'h20, 6'h21: {wr, data} = {1'b1, a + b};
				6'h22, 6'h23: {wr, data} = {1'b1, a - b};
				6'h24: {wr, data} = {1'b1, a & b};
				6'h25: {wr, data} = {1'b1, a | b};
				6'h26: {wr, data} = {1'b1, a ^ b};
				6'h27: {wr, data} = {1'b1, ~(a | b)};
				6'h2a: {wr, data} = {1'b1, 31'b0, $signed(a) < $signed(b)};
				6'h2b: {wr, data} = {1'b1, 31'b0, a < b};
				6'h00: {wr, data} = {1'b1, b << sh};
				6'h02: {wr, data} = {1'b1, b >> sh};
				6'h03: {wr, data} = {1'b1, 32'($signed(b) >>> sh)};
				6'h04: {wr, data} = {1'b1, b << a[4:0]};
				6'h06: {wr, data} = {1'b1, b >> a[4:0]};
				6'h07: {wr, data} = {1'b1, 32'($signed(b) >>> a[4:0])};
				6'h08: {e.redirect, e.checkTarget, e.target} = {2'b11, a};
				6'h09: begin
					{e.redirect, e.checkTarget, e.target} = {2'b11, a};
					{wr, data} = {1'b1, pcVal + 32'd8};
				end
				6'h10: {wr, data} = {1'b1, modelHi};
				6'h12: {wr, data} = {1'b1, modelLo};
				6'h11: modelHi = a;
				6'h13: modelLo = a;
				6'h18: begin
					// Low 64 bits of the sign-extended product give the signed result
					prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
					{modelHi, modelLo} = prod;
				end
				6'h19: begin
					prod = {32'h0, a} * {32'h0, b};
					{modelHi, modelLo} = prod;
				end
				default: wr = 1'b0;
			endcase
		end
		6'h01: begin
			isBr = (rtF == 5'h00) || (rtF == 5'h01);
			take = (rtF == 5'h00) ? a[31] : !a[31];
		end
		6'h02: {e.redirect, e.checkTarget, e.target} = {2'b11, pc4[31:28], ins[25:0], 2'b00};
		6'h03: begin
			{e.redirect, e.checkTarget, e.target} = {2'b11, pc4[31:28], ins[25:0], 2'b00};
			{wr, dst, data} = {1'b1, 5'd31, pcVal + 32'd8};
		end
		6'h04: {isBr, take} = {1'b1, a == b};
		6'h05: {isBr, take} = {1'b1, a != b};
		6'h06: {isBr, take} = {1'b1, a[31] || (a == 0)};
		6'h07: {isBr, take} = {1'b1, !a[31] && (a != 0)};
		6'h08, 6'h09: {wr, dst, data} = {1'b1, rtF, a + sImm};
		6'h0a: {wr, dst, data} = {1'b1, rtF, 31'b0, $signed(a) < $signed(sImm)};
		6'h0b: {wr, dst, data} = {1'b1, rtF, 31'b0, a < sImm};
		6'h0c: {wr, dst, data} = {1'b1, rtF, a & zImm};
		6'h0d: {wr, dst, data} = {1'b1, rtF, a | zImm};
		6'h0e: {wr, dst, data} = {1'b1, rtF, a ^ zImm};
		6'h0f: {wr, dst, data} = {1'b1, rtF, ins[15:0], 16'h0000};
		default: wr = 1'b0;
	endcase
	if (isBr) begin
		{e.redirect, e.checkTarget} = {take, 1'b1};
		e.target = pc4 + {sImm[29:0], 2'b00};
	end
	e.wbEn = wr && (dst != 5'd0);
	e.wbReg = dst;
	e.wbData = data;
	return e;
endfunction

`endif

// File: tests/execCoreTb.sv
module execCoreTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned Seed = 72936;
	localparam int NumInstr = 2000;
	localparam int TimeoutCycles = NumInstr * 3 + 100;

	// Candidate codes with the dropped div and movz listed last
	localparam logic [26*6-1:0] SpecialFns = {
		6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b,
		6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09, 6'h10, 6'h11,
		6'h12, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h0a
	};
	localparam logic [14*6-1:0] MainOps = {
		6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07, 6'h08,
		6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f
	};
	// Loads, stores and unused opcodes
	localparam logic [5*6-1:0] UndefOps = {6'h20, 6'h23, 6'h2b, 6'h1c, 6'h3f};

	logic        clk = 1'b0;
	logic        arstN;
	logic        instrValid;
	logic [31:0] instr;
	logic [31:0] pc;
	logic [31:0] rsVal;
	logic [31:0] rtVal;
	logic        resValid;
	logic        wbEn;
	logic [4:0]  wbReg;
	logic [31:0] wbData;
	logic        redirect;
	logic [31:0] target;
	int unsigned cycleCount = 0;

	`include "mipsModel.svh"

	expect_t expQ[$];

	execCore u_dut (
		.clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr), .pc(pc),
		.rsVal(rsVal), .rtVal(rtVal), .resValid(resValid), .wbEn(wbEn), .wbReg(wbReg),
		.wbData(wbData), .redirect(redirect), .target(target)
	);

	always #2 clk = ~clk;

	always @(posedge clk) cycleCount <= cycleCount + 1;

	task automatic stopOnFailure();
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic checkWord(input string name, input logic [31:0] expVal,
			input logic [31:0] actVal);
		assert (actVal === expVal) else begin
			$display("ERROR: %s expected %h got %h", name, expVal, actVal);
			stopOnFailure();
		end
	endtask

	function automatic logic [31:0] makeInstr();
		logic [31:0] w;
		int unsigned pick;
		int unsigned idx;
		w = $urandom;
		pick = $urandom_range(0, 99);
		if ($urandom_range(0, 15) == 0) begin
			w[20:11] = '0;
		end
		if (pick < 45) begin
			idx = $urandom_range(0, 25);
			w[31:26] = 6'h00;
			w[5:0] = SpecialFns[idx*6 +: 6];
		end else if (pick < 85) begin
			idx = $urandom_range(0, 13);
			w[31:26] = MainOps[idx*6 +: 6];
		end else if (pick < 92) begin
			idx = $urandom_range(0, 2);
			w[31:26] = 6'h01;
			// rt 0x10 is bltzal which is not kept
			w[20:16] = (idx == 2) ? 5'h10 : idx[4:0];
		end else begin
			idx = $urandom_range(0, 4);
			w[31:26] = UndefOps[idx*6 +: 6];
		end
		return w;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		int issued;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] p;
		expect_t e;
		void'($urandom(Seed));
		issued = 0;
		arstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		rsVal = '0;
		rtVal = '0;
		repeat (16) @(posedge clk);
		arstN <= 1'b1;
		repeat (2) @(posedge clk);
		while (issued < NumInstr) begin
			@(posedge clk);
			if ($urandom_range(0, 3) == 0) begin
				instrValid <= 1'b0;
			end else begin
				w = makeInstr();
				// mfhi then mflo first, to read HI and LO as left by reset
				if (issued < 2) begin
					w = {16'h0000, 5'd2, 5'd0, (issued == 0) ? 6'h10 : 6'h12};
				end
				a = ($urandom_range(0, 7) == 0) ? 32'd0 : $urandom;
				b = ($urandom_range(0, 3) == 0) ? a : $urandom;
				p = $urandom & 32'hffff_fffc;
				e = predictInstr(w, p, a, b);
				// Strobe is seen in the cycle after this edge
				e.issueCycle = cycleCount + 1;
				expQ.push_back(e);
				instrValid <= 1'b1;
				instr <= w;
				pc <= p;
				rsVal <= a;
				rtVal <= b;
				issued++;
			end
		end
		@(posedge clk);
		instrValid <= 1'b0;
		for (int i = 0; i < 8 && expQ.size() != 0; i++) begin
			@(posedge clk);
		end
		if (expQ.size() != 0) begin
			$display("%0d issued instructions never produced a result", expQ.size());
			stopOnFailure();
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Scoreboard on the falling edge
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin : scoreboard
		expect_t e;
		if (resValid === 1'b1) begin
			assert (expQ.size() != 0) else begin
				$display("A result beat appeared with no instruction outstanding");
				stopOnFailure();
			end
			e = expQ.pop_front();
			checkWord("result cycle", e.issueCycle + 2, cycleCount);
			checkWord("wbEn", e.wbEn, wbEn);
			if (e.wbEn) begin
				checkWord("wbReg", e.wbReg, wbReg);
				checkWord("wbData", e.wbData, wbData);
			end
			checkWord("redirect", e.redirect, redirect);
			if (e.checkTarget) begin
				checkWord("target", e.target, target);
			end
		end else begin
			assert (resValid === 1'b0) else begin
				$display("resValid is neither high nor low");
				stopOnFailure();
			end
			checkWord("wbEn", 32'd0, wbEn);
			checkWord("redirect", 32'd0, redirect);
		end
	end

	always @(posedge clk) begin
		assert (cycleCount < TimeoutCycles) else begin
			$display("The run did not finish within %0d cycles", TimeoutCycles);
			stopOnFailure();
		end
	end

endmodule
